// File: tetris_params.svh
`ifndef TETRIS_PARAMS_SVH
`define TETRIS_PARAMS_SVH

// Widths of a 4x4 shape mask and a sprite index.
`define BLOCK_W 16
`define SPRITE_W 6

// Host keycodes that map to commands.
`define KEY_SPACE  8'h2C
`define KEY_PAUSE  8'h13
`define KEY_RESUME 8'h18
`define KEY_TAB    8'h2B
`define KEY_ESC    8'h29

// Tetromino masks, row 0 in the top nibble.
`define SHAPE_0 16'h00F0
`define SHAPE_1 16'h0660
`define SHAPE_2 16'h0E40
`define SHAPE_3 16'h06C0
`define SHAPE_4 16'h0C60
`define SHAPE_5 16'h08E0
`define SHAPE_6 16'h02E0

// Piece LFSR start value.
`define LFSR_SEED 8'h01

`endif

// File: tetrisPkg.sv
package tetrisPkg;

	// Game FSM states, one 3-bit word.
	typedef enum logic [2:0]
	{
		Wait,
		Drop,
		DropNoReset,
		Falling,
		Hold,
		Bottom,
		PauseState,
		EndScreen
	} gameStateT;

	// Single-cycle commands from the key decoder.
	typedef enum logic [2:0]
	{
		CmdNone,
		CmdStart,
		CmdPause,
		CmdResume,
		CmdHold,
		CmdEscape
	} gameCmdT;

endpackage

// File: keyDecoder.sv
`include "tetris_params.svh"

module keyDecoder
	import tetrisPkg::*;
(
	input  logic       Clk,
	input  logic       rstN,
	input  logic       keyReq,
	input  logic [7:0] keyCode,
	output logic       keyAck,
	output gameCmdT    cmd
);

	logic accept;

	// Keycode to command map, unknown codes give no command.
	function automatic gameCmdT mapKey(input logic [7:0] code);
		gameCmdT result;
		begin
			case (code)
				`KEY_SPACE:  result = CmdStart;
				`KEY_PAUSE:  result = CmdPause;
				`KEY_RESUME: result = CmdResume;
				`KEY_TAB:    result = CmdHold;
				`KEY_ESC:    result = CmdEscape;
				default:     result = CmdNone;
			endcase
			return result;
		end
	endfunction

	// New request seen while idle.
	assign accept = keyReq && !keyAck;

	// keyAck doubles as the responder state: low is idle, high waits for the drop.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			keyAck <= 1'b0;
		end
		else if (accept)
		begin
			keyAck <= 1'b1;
		end
		else if (keyAck && !keyReq)
		begin
			keyAck <= 1'b0;
		end
	end

	// Code is captured once per transaction, so a held request pulses only once.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			cmd <= CmdNone;
		end
		else if (accept)
		begin
			cmd <= mapKey(keyCode);
		end
		else
		begin
			cmd <= CmdNone;
		end
	end

endmodule

// File: pieceGenerator.sv
`include "tetris_params.svh"

module pieceGenerator
	import tetrisPkg::*;
(
	input  logic                 Clk,
	input  logic                 rstN,
	input  logic                 pickPiece,
	output logic [`BLOCK_W-1:0]  pickShape,
	output logic [`SPRITE_W-1:0] pickSprite
);

	logic [7:0] lfsr;
	logic       feedback;
	logic [2:0] pieceId;

	// x^8+x^6+x^5+x^4+1, Fibonacci form.
	assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	// The LFSR steps every cycle, so a held pick yields a new piece each cycle.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			lfsr <= `LFSR_SEED;
		end
		else
		begin
			lfsr <= {lfsr[6:0], feedback};
		end
	end

	assign pieceId = 3'(lfsr % 8'd7);

	always_comb
	begin
		case (pieceId)
			3'd0:    pickShape = `SHAPE_0;
			3'd1:    pickShape = `SHAPE_1;
			3'd2:    pickShape = `SHAPE_2;
			3'd3:    pickShape = `SHAPE_3;
			3'd4:    pickShape = `SHAPE_4;
			3'd5:    pickShape = `SHAPE_5;
			default: pickShape = `SHAPE_6;
		endcase
	end

	// Eight sprites per shape.
	assign pickSprite = {pieceId, 3'b000};

endmodule

// File: gameControl.sv
`include "tetris_params.svh"

module gameControl
	import tetrisPkg::*;
(
	input  logic                 Clk,
	input  logic                 rstN,
	input  gameCmdT              cmd,
	input  logic                 hitBottom,
	input  logic                 endGame,
	input  logic [`BLOCK_W-1:0]  pickShape,
	input  logic [`SPRITE_W-1:0] pickSprite,
	output logic                 pickPiece,
	output gameStateT            state,
	output logic [`BLOCK_W-1:0]  curShape,
	output logic [`SPRITE_W-1:0] curSprite,
	output logic [`BLOCK_W-1:0]  nextShape,
	output logic [`SPRITE_W-1:0] nextSprite,
	output logic [`BLOCK_W-1:0]  holdShape,
	output logic [`SPRITE_W-1:0] holdSprite,
	output logic                 resetBlocks,
	output logic                 paused,
	output logic [2:0]           screen
);

	gameStateT            stateNxt;
	logic                 canHold;
	logic                 canHoldNxt;
	logic                 resetBlocksNxt;
	logic                 holdEmpty;
	logic [`BLOCK_W-1:0]  curShapeNxt;
	logic [`BLOCK_W-1:0]  nextShapeNxt;
	logic [`BLOCK_W-1:0]  holdShapeNxt;
	logic [`SPRITE_W-1:0] curSpriteNxt;
	logic [`SPRITE_W-1:0] nextSpriteNxt;
	logic [`SPRITE_W-1:0] holdSpriteNxt;

	// Shape masks are never zero, so a zero mask means nothing is held.
	assign holdEmpty = (holdShape == '0);

	always_comb
	begin
		stateNxt = state;
		case (state)
			Wait:
				if (cmd == CmdStart)
					stateNxt = Drop;
			Drop, DropNoReset:
				stateNxt = Falling;
			Falling:
			begin
				if (hitBottom)
					stateNxt = Bottom;
				else if (cmd == CmdPause)
					stateNxt = PauseState;
				else if (cmd == CmdHold && canHold)
					stateNxt = Hold;
				else if (cmd == CmdEscape)
					stateNxt = Wait;
			end
			Hold:
				stateNxt = DropNoReset;
			Bottom:
				stateNxt = endGame ? EndScreen : Drop;
			PauseState:
				if (cmd == CmdResume)
					stateNxt = Falling;
			EndScreen:
				if (cmd == CmdEscape)
					stateNxt = Wait;
			default:
				stateNxt = Wait;
		endcase
	end

	// Piece queue and hold slot.
	always_comb
	begin
		pickPiece     = 1'b0;
		canHoldNxt    = canHold;
		curShapeNxt   = curShape;
		curSpriteNxt  = curSprite;
		nextShapeNxt  = nextShape;
		nextSpriteNxt = nextSprite;
		holdShapeNxt  = holdShape;
		holdSpriteNxt = holdSprite;
		case (state)
			Wait:
			begin
				pickPiece     = 1'b1;
				nextShapeNxt  = pickShape;
				nextSpriteNxt = pickSprite;
			end
			Drop:
			begin
				pickPiece     = 1'b1;
				curShapeNxt   = nextShape;
				curSpriteNxt  = nextSprite;
				nextShapeNxt  = pickShape;
				nextSpriteNxt = pickSprite;
			end
			Hold:
			begin
				canHoldNxt    = 1'b0;
				holdShapeNxt  = curShape;
				holdSpriteNxt = curSprite;
				if (holdEmpty)
				begin
					pickPiece     = 1'b1;
					curShapeNxt   = nextShape;
					curSpriteNxt  = nextSprite;
					nextShapeNxt  = pickShape;
					nextSpriteNxt = pickSprite;
				end
				else
				begin
					curShapeNxt  = holdShape;
					curSpriteNxt = holdSprite;
				end
			end
			Bottom:
				canHoldNxt = 1'b1;
			default:
			begin
			end
		endcase
	end

	// Playfield respawns after these states.
	assign resetBlocksNxt = (state == Wait) || (state == Drop) ||
		(state == DropNoReset) || (state == EndScreen);

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state       <= Wait;
			canHold     <= 1'b1;
			resetBlocks <= 1'b0;
			curShape    <= '0;
			curSprite   <= '0;
			nextShape   <= '0;
			nextSprite  <= '0;
			holdShape   <= '0;
			holdSprite  <= '0;
		end
		else
		begin
			state       <= stateNxt;
			canHold     <= canHoldNxt;
			resetBlocks <= resetBlocksNxt;
			curShape    <= curShapeNxt;
			curSprite   <= curSpriteNxt;
			nextShape   <= nextShapeNxt;
			nextSprite  <= nextSpriteNxt;
			holdShape   <= holdShapeNxt;
			holdSprite  <= holdSpriteNxt;
		end
	end

	// Screen select: 2 title, 1 pause, 3 end, 0 play.
	always_comb
	begin
		case (state)
			Wait:       screen = 3'd2;
			PauseState: screen = 3'd1;
			EndScreen:  screen = 3'd3;
			default:    screen = 3'd0;
		endcase
	end

	assign paused = (state == Wait) || (state == PauseState) || (state == EndScreen);

endmodule

// File: gameStats.sv
module gameStats
	import tetrisPkg::*;
(
	input  logic       Clk,
	input  logic       rstN,
	input  gameStateT  state,
	output logic [11:0] piecesPlaced,
	output logic [7:0]  holdsUsed
);

	// One landing per Bottom cycle.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			piecesPlaced <= '0;
		end
		else if (state == Wait)
		begin
			piecesPlaced <= '0;
		end
		else if (state == Bottom && piecesPlaced != '1)
		begin
			piecesPlaced <= piecesPlaced + 12'd1;
		end
	end

	// One swap per Hold cycle, saturating.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			holdsUsed <= '0;
		end
		else if (state == Wait)
		begin
			holdsUsed <= '0;
		end
		else if (state == Hold && holdsUsed != '1)
		begin
			holdsUsed <= holdsUsed + 8'd1;
		end
	end

endmodule

// File: tetrisTop.sv
`include "tetris_params.svh"

module tetrisTop
	import tetrisPkg::*;
(
	input  logic                 Clk,
	input  logic                 rstN,
	input  logic                 keyReq,
	input  logic [7:0]           keyCode,
	input  logic                 hitBottom,
	input  logic                 endGame,
	output logic                 keyAck,
	output logic [`BLOCK_W-1:0]  curShape,
	output logic [`SPRITE_W-1:0] curSprite,
	output logic [`BLOCK_W-1:0]  nextShape,
	output logic [`SPRITE_W-1:0] nextSprite,
	output logic [`BLOCK_W-1:0]  holdShape,
	output logic [`SPRITE_W-1:0] holdSprite,
	output logic                 resetBlocks,
	output logic                 paused,
	output logic [2:0]           screen,
	output logic [11:0]          piecesPlaced,
	output logic [7:0]           holdsUsed
);

	gameCmdT              cmd;
	gameStateT            state;
	logic                 pickPiece;
	logic [`BLOCK_W-1:0]  pickShape;
	logic [`SPRITE_W-1:0] pickSprite;

	keyDecoder keyDecoder
	(
		.Clk     (Clk),
		.rstN    (rstN),
		.keyReq  (keyReq),
		.keyCode (keyCode),
		.keyAck  (keyAck),
		.cmd     (cmd)
	);

	pieceGenerator pieceGenerator
	(
		.Clk        (Clk),
		.rstN       (rstN),
		.pickPiece  (pickPiece),
		.pickShape  (pickShape),
		.pickSprite (pickSprite)
	);

	gameControl gameControl
	(
		.Clk         (Clk),
		.rstN        (rstN),
		.cmd         (cmd),
		.hitBottom   (hitBottom),
		.endGame     (endGame),
		.pickShape   (pickShape),
		.pickSprite  (pickSprite),
		.pickPiece   (pickPiece),
		.state       (state),
		.curShape    (curShape),
		.curSprite   (curSprite),
		.nextShape   (nextShape),
		.nextSprite  (nextSprite),
		.holdShape   (holdShape),
		.holdSprite  (holdSprite),
		.resetBlocks (resetBlocks),
		.paused      (paused),
		.screen      (screen)
	);

	gameStats gameStats
	(
		.Clk          (Clk),
		.rstN         (rstN),
		.state        (state),
		.piecesPlaced (piecesPlaced),
		.holdsUsed    (holdsUsed)
	);

endmodule

// File: tbTetris.sv
`include "tetris_params.svh"

module tbTetris
	import tetrisPkg::*;
();

	localparam int NUM_TX = 300;
	localparam int MAX_GAP = 8;
	localparam int TIMEOUT_CYCLES = 4 * NUM_TX * MAX_GAP + 200;

	logic                 Clk;
	logic                 rstN;
	logic                 keyReq;
	logic [7:0]           keyCode;
	logic                 hitBottom;
	logic                 endGame;
	logic                 keyAck;
	logic [`BLOCK_W-1:0]  curShape;
	logic [`SPRITE_W-1:0] curSprite;
	logic [`BLOCK_W-1:0]  nextShape;
	logic [`SPRITE_W-1:0] nextSprite;
	logic [`BLOCK_W-1:0]  holdShape;
	logic [`SPRITE_W-1:0] holdSprite;
	logic                 resetBlocks;
	logic                 paused;
	logic [2:0]           screen;
	logic [11:0]          piecesPlaced;
	logic [7:0]           holdsUsed;

	integer seed;
	int     errorCount;
	int     protocolErrors;
	int     coverageMisses;
	int     cycleCount;
	int     covHold;
	int     covSwap;
	int     covPause;
	int     covEnd;
	logic   prevReq;
	logic   prevAck;

	// Reference model.
	logic [7:0]           mLfsr;
	logic                 mAck;
	gameCmdT              mCmd;
	gameStateT            mState;
	logic                 mCanHold;
	logic                 mHeld;
	logic                 mResetBlocks;
	logic [`BLOCK_W-1:0]  mCur;
	logic [`SPRITE_W-1:0] mCurSpr;
	logic [`BLOCK_W-1:0]  mNext;
	logic [`SPRITE_W-1:0] mNextSpr;
	logic [`BLOCK_W-1:0]  mHoldS;
	logic [`SPRITE_W-1:0] mHoldSpr;
	logic [11:0]          mPieces;
	logic [7:0]           mHolds;

	tetrisTop uut (.*);

	initial
	begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	function automatic gameCmdT keyToCmd(input logic [7:0] code);
		if (code == `KEY_SPACE) return CmdStart;
		if (code == `KEY_PAUSE) return CmdPause;
		if (code == `KEY_RESUME) return CmdResume;
		if (code == `KEY_TAB) return CmdHold;
		if (code == `KEY_ESC) return CmdEscape;
		return CmdNone;
	endfunction

	function automatic logic [`BLOCK_W-1:0] shapeOf(input int id);
		case (id)
			0:       return `SHAPE_0;
			1:       return `SHAPE_1;
			2:       return `SHAPE_2;
			3:       return `SHAPE_3;
			4:       return `SHAPE_4;
			5:       return `SHAPE_5;
			default: return `SHAPE_6;
		endcase
	endfunction

	// Mostly command keys, a few arbitrary bytes.
	function automatic logic [7:0] drawKey();
		int sel;
		sel = $unsigned($random(seed)) % 16;
		if (sel < 4) return `KEY_SPACE;
		if (sel < 6) return `KEY_PAUSE;
		if (sel < 9) return `KEY_RESUME;
		if (sel < 12) return `KEY_TAB;
		if (sel < 14) return `KEY_ESC;
		return 8'($random(seed));
	endfunction

	task automatic resetModel();
		mLfsr        = `LFSR_SEED;
		mAck         = 1'b0;
		mCmd         = CmdNone;
		mState       = Wait;
		mCanHold     = 1'b1;
		mHeld        = 1'b0;
		mResetBlocks = 1'b0;
		mCur         = '0;
		mCurSpr      = '0;
		mNext        = '0;
		mNextSpr     = '0;
		mHoldS       = '0;
		mHoldSpr     = '0;
		mPieces      = '0;
		mHolds       = '0;
	endtask

	// One clock of the whole subsystem, using the inputs seen at this edge.
	task automatic stepModel();
		int                   pickId;
		logic [`BLOCK_W-1:0]  pShape;
		logic [`SPRITE_W-1:0] pSprite;
		logic [`BLOCK_W-1:0]  tmpShape;
		logic [`SPRITE_W-1:0] tmpSprite;
		logic                 accept;
		gameStateT            nState;
		pickId = int'(mLfsr) % 7;
		pShape = shapeOf(pickId);
		pSprite = 6'(pickId * 8);
		accept = keyReq && !mAck;
		if (mState == Wait)
		begin
			mPieces = '0;
			mHolds = '0;
		end
		else if (mState == Bottom && mPieces != 12'hFFF)
			mPieces = mPieces + 12'd1;
		else if (mState == Hold && mHolds != 8'hFF)
			mHolds = mHolds + 8'd1;
		mResetBlocks = (mState == Wait) || (mState == Drop) || (mState == DropNoReset) ||
			(mState == EndScreen);
		nState = mState;
		case (mState)
			Wait:
			begin
				mNext = pShape;
				mNextSpr = pSprite;
				if (mCmd == CmdStart)
					nState = Drop;
			end
			Drop:
			begin
				mCur = mNext;
				mCurSpr = mNextSpr;
				mNext = pShape;
				mNextSpr = pSprite;
				nState = Falling;
			end
			DropNoReset:
				nState = Falling;
			Falling:
				if (hitBottom)
					nState = Bottom;
				else if (mCmd == CmdPause)
					nState = PauseState;
				else if (mCmd == CmdHold && mCanHold)
					nState = Hold;
				else if (mCmd == CmdEscape)
					nState = Wait;
			Hold:
			begin
				mCanHold = 1'b0;
				nState = DropNoReset;
				tmpShape = mCur;
				tmpSprite = mCurSpr;
				if (!mHeld)
				begin
					covHold++;
					mHeld = 1'b1;
					mCur = mNext;
					mCurSpr = mNextSpr;
					mNext = pShape;
					mNextSpr = pSprite;
				end
				else
				begin
					covSwap++;
					mCur = mHoldS;
					mCurSpr = mHoldSpr;
				end
				mHoldS = tmpShape;
				mHoldSpr = tmpSprite;
			end
			Bottom:
			begin
				mCanHold = 1'b1;
				nState = endGame ? EndScreen : Drop;
			end
			PauseState:
			begin
				covPause++;
				if (mCmd == CmdResume)
					nState = Falling;
			end
			default:
			begin
				covEnd++;
				if (mCmd == CmdEscape)
					nState = Wait;
			end
		endcase
		mState = nState;
		mCmd = accept ? keyToCmd(keyCode) : CmdNone;
		if (accept)
			mAck = 1'b1;
		else if (mAck && !keyReq)
			mAck = 1'b0;
		mLfsr = {mLfsr[6:0], mLfsr[7] ^ mLfsr[5] ^ mLfsr[4] ^ mLfsr[3]};
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			errorCount++;
			$display("CHECK FAILED t=%0t %s: expected %0h, got %0h", $time, name, expected,
				actual);
		end
	endtask

	// Advance one edge and redraw the playfield levels.
	task automatic nextCycle();
		@(posedge Clk);
		hitBottom <= ($unsigned($random(seed)) % 16) == 0;
		endGame <= ($unsigned($random(seed)) % 5) == 0;
	endtask

	task automatic sendKey(input logic [7:0] code);
		keyCode <= code;
		keyReq <= 1'b1;
		nextCycle();
		while (!keyAck)
			nextCycle();
		keyReq <= 1'b0;
		nextCycle();
		while (keyAck)
			nextCycle();
	endtask

	always @(posedge Clk)
	begin
		if (!rstN)
			resetModel();
		else
			stepModel();
	end

	always @(negedge Clk)
	begin
		if (rstN)
		begin
			if (keyAck && !prevAck && !prevReq)
			begin
				protocolErrors++;
				$display("Handshake error at %0t: keyAck rose with no request pending", $time);
			end
			if (!keyAck && prevAck && prevReq)
			begin
				protocolErrors++;
				$display("Handshake error at %0t: keyAck fell while keyReq was high", $time);
			end
			checkValue("keyAck", 32'(mAck), 32'(keyAck));
			checkValue("curShape", 32'(mCur), 32'(curShape));
			checkValue("curSprite", 32'(mCurSpr), 32'(curSprite));
			checkValue("nextShape", 32'(mNext), 32'(nextShape));
			checkValue("nextSprite", 32'(mNextSpr), 32'(nextSprite));
			checkValue("holdShape", 32'(mHoldS), 32'(holdShape));
			checkValue("holdSprite", 32'(mHoldSpr), 32'(holdSprite));
			checkValue("resetBlocks", 32'(mResetBlocks), 32'(resetBlocks));
			checkValue("paused", 32'(mState == Wait || mState == PauseState ||
				mState == EndScreen), 32'(paused));
			checkValue("screen", (mState == Wait) ? 32'd2 : (mState == PauseState) ? 32'd1 :
				(mState == EndScreen) ? 32'd3 : 32'd0, 32'(screen));
			checkValue("piecesPlaced", 32'(mPieces), 32'(piecesPlaced));
			checkValue("holdsUsed", 32'(mHolds), 32'(holdsUsed));
		end
		prevReq = keyReq;
		prevAck = keyAck;
	end

	always @(posedge Clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors: %0d value, %0d protocol, %0d coverage", errorCount,
				protocolErrors, coverageMisses);
			$display("Something failed");
			$finish;
		end
	end

	initial
	begin
		int gap;
		seed = 34341;
		rstN = 1'b0;
		keyReq = 1'b0;
		keyCode = 8'h00;
		hitBottom = 1'b0;
		endGame = 1'b0;
		repeat (3)
			nextCycle();
		rstN <= 1'b1;
		nextCycle();
		for (int i = 0; i < NUM_TX; i++)
		begin
			gap = $unsigned($random(seed)) % (MAX_GAP + 1);
			repeat (gap)
				nextCycle();
			sendKey(drawKey());
		end
		repeat (20)
			nextCycle();
		if (covHold == 0 || covSwap == 0 || covPause == 0 || covEnd == 0)
		begin
			coverageMisses++;
			$display("Stimulus never reached a first hold, a swap, a pause or the end screen");
		end
		$display("Errors: %0d value, %0d protocol, %0d coverage", errorCount, protocolErrors,
			coverageMisses);
		if (errorCount == 0 && protocolErrors == 0 && coverageMisses == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+.
tetrisPkg.sv
keyDecoder.sv
pieceGenerator.sv
gameControl.sv
gameStats.sv
tetrisTop.sv
tbTetris.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tbTetris -f files.f -o simTetris

run: compile
	@out=$$(./obj_dir/simTetris); echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
